/* testbench/fir_stim.txt */
# One record per line, fields separated by spaces.
# T <test name> <gaps>     starts a section, gaps 1 adds 0 to 3 idle cycles per sample
# W <tap> <coefficient>    writes one coefficient, 64 means a gain of 1.0
# S <sample> <expected>    sends one sample together with its expected output
T impulse 0
W 0 16
W 1 -8
W 2 32
W 3 64
W 4 -32
W 5 4
W 6 127
W 7 -128
S 64 16
S 0 -8
S 0 32
S 0 64
S 0 -32
S 0 4
S 0 127
S 0 -128
# Full reload while the last impulse beats are still in the pipeline.
T convolution 1
W 0 32
W 1 16
W 2 -16
W 3 8
W 4 0
W 5 0
W 6 0
W 7 0
S 1 1
S 3 2
S -5 -2
S 10 3
S -7 1
S 2 -4
S -8 0
T saturation 0
W 0 127
W 1 127
W 2 127
W 3 127
S 127 127
S 127 127
S -128 127
S -128 -4
S -128 -128
S -128 -128
T reload 1
W 0 64
W 1 0
W 2 0
W 3 0
S 5 5
S -9 -9
T single_index 1
W 2 -32
S 20 18
S -3 2
S 0 -10

/* sim.f */
+incdir+include
source/fir_sample_pkg.sv
source/fir_coeff_pkg.sv
source/sample_delay_line.sv
source/coeff_bank.sv
source/tap_multiplier.sv
source/product_adder.sv
source/output_quantizer.sv
source/fir_filter_top.sv
testbench/fir_filter_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the FIR filter testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal -f sim.f --top-module fir_filter_tb -o fir_sim

# The simulator exits non-zero on a failure, the log decides the result.
./obj_dir/fir_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi

if ! grep -q "ALL TESTS PASSED" "$LOG"; then
    echo "Simulation ended without a result, see $LOG"
    exit 1
fi

echo "Simulation passed"

/* testbench/fir_filter_tb.sv */
`timescale 1ns/1ps
`include "fir_defines.svh"

module fir_filter_tb;

    import fir_sample_pkg::*;
    import fir_coeff_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Run parameters.
    ////////////////////////////////////////////////////////////////////////////

    // A 40 ns clock period.
    localparam int    HALF_PERIOD     = 20;
    localparam int    RESET_CYCLES    = 3;
    localparam int    RESET_CHECKS    = 4;
    localparam int    CYCLES_PER_LINE = 8;
    localparam int    TIMEOUT_MARGIN  = 100;
    localparam int    MAX_GAP         = 3;
    // Delay line, products, sum and output register each add one cycle.
    localparam int    LATENCY         = 4;
    localparam string STIM_FILE       = "testbench/fir_stim.txt";

    logic         clock = 1'b0;
    logic         i_reset;
    sample_beat_t i_sample;
    coeff_wr_t    i_coeff_wr;
    out_t         o_result;
    logic         o_valid;

    // Expected results wait here in input order, each with its section name.
    int    expected_q[$];
    string test_q[$];
    // Cycle count at the falling edge where each queued sample was driven.
    int    issue_q[$];
    string current_test = "reset";
    bit    gaps_enabled = 1'b0;
    int    cycle_count  = 0;
    int    cycle_limit  = TIMEOUT_MARGIN;

    fir_filter_top u_dut
    (
        .clock      (clock),
        .i_reset    (i_reset),
        .i_sample   (i_sample),
        .i_coeff_wr (i_coeff_wr),
        .o_result   (o_result),
        .o_valid    (o_valid)
    );

    always #(HALF_PERIOD) clock = ~clock;

    ////////////////////////////////////////////////////////////////////////////
    // Failure handling and checking.
    ////////////////////////////////////////////////////////////////////////////

    task automatic end_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at the first failure.");
    endtask

    task automatic check_value(input string test_name, input int expected, input int actual);
        if (expected != actual)
        begin
            $display("[FAIL] %s: expected %0d, actual %0d", test_name, expected, actual);
            end_with_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Input drivers.
    ////////////////////////////////////////////////////////////////////////////

    // All inputs change on the falling edge, half a period away from the
    // edge where the DUT samples them.
    task automatic idle_cycles(input int count);
        repeat (count)
        begin
            @(negedge clock);
            i_sample.valid = 1'b0;
            i_coeff_wr.en  = 1'b0;
        end
    endtask

    task automatic write_coeff(input int idx, input int value);
        @(negedge clock);
        i_sample.valid   = 1'b0;
        i_coeff_wr.en    = 1'b1;
        i_coeff_wr.idx   = tap_idx_t'(idx);
        i_coeff_wr.coeff = coeff_t'(value);
    endtask

    task automatic send_sample(input int value, input int expected);
        int gap;
        int issue_cycle;

        gap = 0;
        if (gaps_enabled)
            gap = int'($urandom % (MAX_GAP + 1));
        idle_cycles(gap);
        @(negedge clock);
        i_coeff_wr.en  = 1'b0;
        i_sample.data  = sample_t'(value);
        i_sample.valid = 1'b1;
        issue_cycle    = cycle_count;
        // The sample is taken on this edge.
        // Queueing here keeps the push away from the monitor's edge.
        @(posedge clock);
        expected_q.push_back(expected);
        test_q.push_back(current_test);
        issue_q.push_back(issue_cycle);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Output monitor and timeout.
    ////////////////////////////////////////////////////////////////////////////

    // Outputs move on the rising edge, so they are read on the falling one.
    // Each result must arrive a fixed number of cycles after its sample, so
    // gaps in the input show up unchanged in the output.
    always @(negedge clock)
    begin
        int    expected;
        int    issued;
        string name;

        if (!i_reset && o_valid)
        begin
            if (expected_q.size() == 0)
            begin
                $display("Error: o_valid was high while no result was expected.");
                end_with_failure();
            end
            else
            begin
                expected = expected_q.pop_front();
                name     = test_q.pop_front();
                issued   = issue_q.pop_front();
                check_value({name, " latency"}, LATENCY, cycle_count - issued);
                check_value(name, expected, o_result);
            end
        end
    end

    always @(posedge clock)
    begin
        cycle_count++;
        if (cycle_count > cycle_limit)
        begin
            $display("Error: timeout after %0d cycles, results are still missing.", cycle_count);
            end_with_failure();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence.
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        int    fd;
        int    line_count;
        int    fields;
        int    arg_a;
        int    arg_b;
        string line;
        string kind;
        string name;

        void'($urandom(32'hf432dafc));
        i_reset    = 1'b1;
        i_sample   = '0;
        i_coeff_wr = '0;

        // A first pass over the file sizes the timeout.
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0)
        begin
            $display("Error: the stimulus file %s could not be opened.", STIM_FILE);
            end_with_failure();
        end
        line_count = 0;
        while ($fgets(line, fd) != 0)
            line_count++;
        $fclose(fd);
        cycle_limit = line_count * CYCLES_PER_LINE + TIMEOUT_MARGIN;

        repeat (RESET_CYCLES) @(negedge clock);
        i_reset = 1'b0;

        // Nothing may come out before the first sample goes in.
        repeat (RESET_CHECKS)
        begin
            @(negedge clock);
            check_value("reset valid", 0, o_valid);
            check_value("reset result", 0, o_result);
        end

        fd = $fopen(STIM_FILE, "r");
        while ($fgets(line, fd) != 0)
        begin
            kind   = "";
            fields = $sscanf(line, "%s", kind);
            if (fields >= 1 && kind.substr(0, 0) != "#")
            begin
                if (kind == "T")
                begin
                    fields       = $sscanf(line, "%s %s %d", kind, name, arg_a);
                    current_test = name;
                    gaps_enabled = (arg_a != 0);
                end
                else if (kind == "W" || kind == "S")
                begin
                    fields = $sscanf(line, "%s %d %d", kind, arg_a, arg_b);
                    if (fields != 3)
                    begin
                        $display("Error: a stimulus line is incomplete: %s", line);
                        end_with_failure();
                    end
                    if (kind == "S")
                        send_sample(arg_a, arg_b);
                    else if (arg_a >= 0 && arg_a < `FIR_NTAPS)
                        write_coeff(arg_a, arg_b);
                    else
                    begin
                        $display("Error: tap index %0d is out of range.", arg_a);
                        end_with_failure();
                    end
                end
                else
                begin
                    $display("Error: unknown record type in line: %s", line);
                    end_with_failure();
                end
            end
        end
        $fclose(fd);

        // Let the pipeline drain, then watch a while for stray beats.
        // A missing result ends in the timeout and an extra one in the
        // monitor, so one result came out per sample once this returns.
        while (expected_q.size() != 0)
            idle_cycles(1);
        idle_cycles(CYCLES_PER_LINE);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* source/fir_filter_top.sv */
`timescale 1ns/1ps
`include "fir_defines.svh"

module fir_filter_top
(
    input  logic                         clock,
    input  logic                         i_reset,
    input  fir_sample_pkg::sample_beat_t i_sample,
    input  fir_coeff_pkg::coeff_wr_t     i_coeff_wr,
    output fir_sample_pkg::out_t         o_result,
    output logic                         o_valid
);

    import fir_sample_pkg::*;
    import fir_coeff_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Inter-stage signals.
    ////////////////////////////////////////////////////////////////////////////

    // Latency from input beat to o_valid is four cycles.
    // Delay line, products, sum and output each add one register.
    tap_vec_t      taps;
    logic          tap_valid;
    coeff_vec_t    coeffs;
    product_beat_t products;
    sum_beat_t     sum;

    ////////////////////////////////////////////////////////////////////////////
    // Front end.
    ////////////////////////////////////////////////////////////////////////////

    sample_delay_line
    #(
        .NB_DATA (`FIR_NB_SAMPLE),
        .DELAY   (`FIR_NTAPS)
    )
    u_sample_delay_line
    (
        .clock   (clock),
        .i_reset (i_reset),
        .i_data  (i_sample.data),
        .i_valid (i_sample.valid),
        .o_taps  (taps),
        .o_valid (tap_valid)
    );

    // Coefficients can be rewritten at any time.
    coeff_bank u_coeff_bank
    (
        .clock    (clock),
        .i_reset  (i_reset),
        .i_wr     (i_coeff_wr),
        .o_coeffs (coeffs)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Arithmetic pipeline.
    ////////////////////////////////////////////////////////////////////////////

    tap_multiplier u_tap_multiplier
    (
        .clock      (clock),
        .i_reset    (i_reset),
        .i_taps     (taps),
        .i_valid    (tap_valid),
        .i_coeffs   (coeffs),
        .o_products (products)
    );

    product_adder u_product_adder
    (
        .clock      (clock),
        .i_reset    (i_reset),
        .i_products (products),
        .o_sum      (sum)
    );

    output_quantizer u_output_quantizer
    (
        .clock    (clock),
        .i_reset  (i_reset),
        .i_sum    (sum),
        .o_result (o_result),
        .o_valid  (o_valid)
    );

endmodule

/* source/output_quantizer.sv */
`timescale 1ns/1ps
`include "fir_defines.svh"

module output_quantizer
(
    input  logic                      clock,
    input  logic                      i_reset,
    input  fir_sample_pkg::sum_beat_t i_sum,
    output fir_sample_pkg::out_t      o_result,
    output logic                      o_valid
);

    import fir_sample_pkg::*;

    // One guard bit above the sum, so adding the rounding constant can
    // never overflow.
    localparam int NB_RND = $bits(sum_t) + 1;

    // Half an output LSB, expressed in coefficient fractional units.
    localparam logic signed [NB_RND-1:0] ROUND_HALF = 1 << (`FIR_COEFF_FRAC - 1);

    // Limits of the signed output range.
    localparam logic signed [NB_RND-1:0] OUT_MAX = 2**(`FIR_NB_OUT - 1) - 1;
    localparam logic signed [NB_RND-1:0] OUT_MIN = -(2**(`FIR_NB_OUT - 1));

    ////////////////////////////////////////////////////////////////////////////
    // Round, shift and saturate.
    ////////////////////////////////////////////////////////////////////////////

    logic signed [NB_RND-1:0] rounded;
    logic signed [NB_RND-1:0] shifted;
    out_t                     sat_comb;

    // Round half up, then an arithmetic shift removes the fractional bits.
    // Negative halves therefore round toward plus infinity.
    always_comb
    begin
        rounded = NB_RND'(i_sum.sum) + ROUND_HALF;
        shifted = rounded >>> `FIR_COEFF_FRAC;
        if (shifted > OUT_MAX)
            sat_comb = out_t'(OUT_MAX);
        else if (shifted < OUT_MIN)
            sat_comb = out_t'(OUT_MIN);
        else
            sat_comb = out_t'(shifted);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output register.
    ////////////////////////////////////////////////////////////////////////////

    // The result only moves on a valid beat and holds between beats.
    always_ff @(posedge clock)
    begin
        if (i_reset)
        begin
            o_result <= '0;
            o_valid  <= 1'b0;
        end
        else
        begin
            o_valid <= i_sum.valid;
            if (i_sum.valid)
                o_result <= sat_comb;
        end
    end

endmodule

/* source/product_adder.sv */
`timescale 1ns/1ps
`include "fir_defines.svh"

module product_adder
(
    input  logic                          clock,
    input  logic                          i_reset,
    input  fir_sample_pkg::product_beat_t i_products,
    output fir_sample_pkg::sum_beat_t     o_sum
);

    import fir_sample_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Accumulation.
    ////////////////////////////////////////////////////////////////////////////

    sum_t sum_comb;
    sum_t sum_reg;
    logic valid_reg;

    // The sum is wide enough for every product at its extreme value,
    // so it can never wrap.
    // Each product is sign extended before it is added.
    always_comb
    begin
        sum_comb = '0;
        for (int k = 0; k < `FIR_NTAPS; k++)
            sum_comb = sum_comb + $signed(i_products.products[k]);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage register.
    ////////////////////////////////////////////////////////////////////////////

    // Sum payload follows the valid beat.
    always_ff @(posedge clock)
    begin
        if (i_products.valid)
            sum_reg <= sum_comb;
    end

    always_ff @(posedge clock)
    begin
        if (i_reset)
            valid_reg <= 1'b0;
        else
            valid_reg <= i_products.valid;
    end

    assign o_sum.sum   = sum_reg;
    assign o_sum.valid = valid_reg;

endmodule

/* source/tap_multiplier.sv */
`timescale 1ns/1ps
`include "fir_defines.svh"

module tap_multiplier
(
    input  logic                          clock,
    input  logic                          i_reset,
    input  fir_sample_pkg::tap_vec_t      i_taps,
    input  logic                          i_valid,
    input  fir_coeff_pkg::coeff_vec_t     i_coeffs,
    output fir_sample_pkg::product_beat_t o_products
);

    import fir_sample_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Parallel multipliers.
    ////////////////////////////////////////////////////////////////////////////

    product_vec_t prod_comb;
    product_vec_t prod_reg;
    logic         valid_reg;

    // Both operands are signed, and the product is sized to hold the full
    // range, so no bits are lost here.
    always_comb
    begin
        for (int k = 0; k < `FIR_NTAPS; k++)
            prod_comb[k] = $signed(i_taps[k]) * $signed(i_coeffs[k]);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage register.
    ////////////////////////////////////////////////////////////////////////////

    // Products are only captured on a valid beat.
    // This keeps the register quiet during idle cycles.
    always_ff @(posedge clock)
    begin
        if (i_valid)
            prod_reg <= prod_comb;
    end

    always_ff @(posedge clock)
    begin
        if (i_reset)
            valid_reg <= 1'b0;
        else
            valid_reg <= i_valid;
    end

    assign o_products.products = prod_reg;
    assign o_products.valid    = valid_reg;

endmodule

/* source/coeff_bank.sv */
`timescale 1ns/1ps
`include "fir_defines.svh"

module coeff_bank
(
    input  logic                       clock,
    input  logic                       i_reset,
    input  fir_coeff_pkg::coeff_wr_t   i_wr,
    output fir_coeff_pkg::coeff_vec_t  o_coeffs
);

    import fir_coeff_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Coefficient registers.
    ////////////////////////////////////////////////////////////////////////////

    coeff_vec_t coeff_reg;

    // Each tap has its own register with a decoded write enable.
    // A write lands on the next edge, so the multiplier sees the new value
    // from the following cycle on.
    always_ff @(posedge clock)
    begin
        for (int k = 0; k < `FIR_NTAPS; k++)
        begin
            if (i_reset)
                coeff_reg[k] <= '0;
            else if (i_wr.en && (i_wr.idx == tap_idx_t'(k)))
                coeff_reg[k] <= i_wr.coeff;
        end
    end

    // The whole bank is visible every cycle.
    // There is no read port, since the multiplier needs all entries at once.
    assign o_coeffs = coeff_reg;

endmodule

/* source/sample_delay_line.sv */
`timescale 1ns/1ps

module sample_delay_line
#(
    parameter NB_DATA = 8,
    parameter DELAY   = 8
)
(
    input  logic                       clock,
    input  logic                       i_reset,
    input  fir_sample_pkg::sample_t    i_data,
    input  logic                       i_valid,
    output fir_sample_pkg::tap_vec_t   o_taps,
    output logic                       o_valid
);

    ////////////////////////////////////////////////////////////////////////////
    // Shift register.
    ////////////////////////////////////////////////////////////////////////////

    // One register per tap, with entry 0 holding the newest sample.
    logic [NB_DATA-1:0] shift_reg [DELAY];

    // The valid strobe works as a clock enable.
    // Idle cycles leave the taps untouched, so the filter only ever sees
    // accepted samples.
    always_ff @(posedge clock)
    begin
        if (i_reset)
        begin
            for (int k = 0; k < DELAY; k++)
                shift_reg[k] <= '0;
        end
        else if (i_valid)
        begin
            shift_reg[0] <= i_data;
            for (int k = 1; k < DELAY; k++)
                shift_reg[k] <= shift_reg[k-1];
        end
    end

    // Flags the cycle in which the taps hold a freshly shifted sample.
    always_ff @(posedge clock)
    begin
        if (i_reset)
            o_valid <= 1'b0;
        else
            o_valid <= i_valid;
    end

    // Every stage is exposed, not only the last one.
    for (genvar k = 0; k < DELAY; k++)
    begin : g_taps
        assign o_taps[k] = shift_reg[k];
    end

endmodule

/* source/fir_coeff_pkg.sv */
`include "fir_defines.svh"

package fir_coeff_pkg;

    // Number of bits needed to address one tap of the bank.
    localparam int NB_TAP_IDX = $clog2(`FIR_NTAPS);

    ////////////////////////////////////////////////////////////////////////////
    // Coefficient storage types.
    ////////////////////////////////////////////////////////////////////////////

    // Signed fixed point value with FIR_COEFF_FRAC fractional bits.
    typedef logic signed [`FIR_NB_COEFF-1:0] coeff_t;

    // Entry k multiplies tap k of the delay line.
    typedef coeff_t [`FIR_NTAPS-1:0] coeff_vec_t;

    typedef logic [NB_TAP_IDX-1:0] tap_idx_t;

    // One write into the bank.
    // The entry selected by idx takes coeff on the clock edge where en is high.
    typedef struct packed {
        logic     en;
        tap_idx_t idx;
        coeff_t   coeff;
    } coeff_wr_t;

endpackage

/* source/fir_sample_pkg.sv */
`include "fir_defines.svh"

package fir_sample_pkg;

    // Derived datapath widths.
    // A product needs the sum of both operand widths, and the adder tree
    // grows by one bit per doubling of the tap count.
    localparam int NB_PRODUCT = `FIR_NB_SAMPLE + `FIR_NB_COEFF;
    localparam int NB_SUM     = NB_PRODUCT + $clog2(`FIR_NTAPS);

    ////////////////////////////////////////////////////////////////////////////
    // Scalar types.
    ////////////////////////////////////////////////////////////////////////////
    typedef logic signed [`FIR_NB_SAMPLE-1:0] sample_t;
    typedef logic signed [NB_PRODUCT-1:0]     product_t;
    typedef logic signed [NB_SUM-1:0]         sum_t;
    typedef logic signed [`FIR_NB_OUT-1:0]    out_t;

    // Index 0 is the newest sample.
    typedef sample_t  [`FIR_NTAPS-1:0] tap_vec_t;
    typedef product_t [`FIR_NTAPS-1:0] product_vec_t;

    ////////////////////////////////////////////////////////////////////////////
    // Valid-tagged beats passed between pipeline stages.
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        sample_t      data;
        logic         valid;
    } sample_beat_t;

    typedef struct packed {
        product_vec_t products;
        logic         valid;
    } product_beat_t;

    typedef struct packed {
        sum_t         sum;
        logic         valid;
    } sum_beat_t;

endpackage

/* include/fir_defines.svh */
`ifndef FIR_DEFINES_SVH
`define FIR_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// FIR filter sizing.
////////////////////////////////////////////////////////////////////////////

// Width of one signed input sample.
`define FIR_NB_SAMPLE   8

// Width of one signed coefficient.
`define FIR_NB_COEFF    8

// Number of taps in the delay line and in the coefficient bank.
`define FIR_NTAPS       8

// Fractional bits of a coefficient, so 64 stands for a gain of 1.0.
`define FIR_COEFF_FRAC  6

// Width of one signed output sample after rounding and saturation.
`define FIR_NB_OUT      8

`endif
